//--- rtl/loader_pkg.sv
package loader_pkg;

    ////////////////////////////////////////
    // Field widths.
    ////////////////////////////////////////
    localparam int WORD_WIDTH = 32;   // Memory word.
    localparam int BYTE_WIDTH = 8;    // UART byte.
    localparam int OPCODE_LSB = 26;   // Low bit of the 6-bit opcode field.

    // Reply codes sent back to the host.
    localparam logic [BYTE_WIDTH-1:0] REPLY_OK  = 8'hAA;
    localparam logic [BYTE_WIDTH-1:0] REPLY_ERR = 8'hEE;

    ////////////////////////////////////////
    // Host command opcodes.
    ////////////////////////////////////////
    typedef enum logic [BYTE_WIDTH-1:0] {
        CMD_WR_PROG = 8'h01,
        CMD_WR_DATA = 8'h02,
        CMD_RD_PROG = 8'h03,
        CMD_RD_DATA = 8'h04,
        CMD_CLEAR   = 8'h05
    } cmd_e;

    // Debug unit FSM.
    typedef enum logic [2:0] {
        IDLE,
        ADDR,
        DATA,
        MEM_ACCESS,
        CLEAR_WAIT,
        SEND
    } dbg_state_e;

endpackage

//--- rtl/mem_port_if.sv
`timescale 1ns/1ps

interface mem_port_if #(
    parameter int ADDR_WIDTH = 11
);
    logic                              en;          // Access strobe.
    logic                              we;          // Write when set with en.
    logic [ADDR_WIDTH-1:0]             addr;
    logic [loader_pkg::WORD_WIDTH-1:0] wdata;
    logic [loader_pkg::WORD_WIDTH-1:0] rdata;       // Valid one cycle after en.
    logic                              soft_reset;  // Level, held until reset_ack.
    logic                              reset_ack;

    // Debug unit side.
    modport master (output en, we, addr, wdata, soft_reset, input rdata, reset_ack);
    // Memory side.
    modport slave (input en, we, addr, wdata, soft_reset, output rdata, reset_ack);

endinterface

//--- rtl/baud_rate_generator.sv
`timescale 1ns/1ps

module baud_rate_generator #(
    parameter int CLKS_PER_TICK = 4
) (
    input  logic i_clock,
    input  logic i_rst_n,
    output logic o_tick
);
    localparam int CNT_WIDTH = $clog2(CLKS_PER_TICK + 1);

    logic [CNT_WIDTH-1:0] count;

    // One pulse on the last count of each period.
    assign o_tick = (count == CNT_WIDTH'(CLKS_PER_TICK - 1));

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            count <= '0;
        end else if (o_tick) begin
            count <= '0;                  // Wrap.
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

//--- rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int STOP_BITS = 1
) (
    input  logic                              i_clock,
    input  logic                              i_rst_n,
    input  logic                              i_tick,
    input  logic                              i_rx,
    output logic                              o_rx_done,
    output logic [loader_pkg::BYTE_WIDTH-1:0] o_data
);
    localparam int BW = loader_pkg::BYTE_WIDTH;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e              state;
    logic [3:0]             tick_cnt;   // 16 ticks per bit.
    logic [$clog2(BW)-1:0]  bit_cnt;
    logic [1:0]             stop_cnt;

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state     <= RX_IDLE;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            stop_cnt  <= '0;
            o_rx_done <= 1'b0;
        end else begin
            o_rx_done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (!i_rx) begin                   // Falling edge of start bit.
                        tick_cnt <= '0;
                        state    <= RX_START;
                    end
                end
                RX_START: begin
                    if (i_tick) begin
                        if (tick_cnt == 4'd7) begin
                            // Middle of start bit. A high line here was a glitch.
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            state    <= i_rx ? RX_IDLE : RX_DATA;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                RX_DATA: begin
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == 4'd15) begin
                            o_data  <= {i_rx, o_data[BW-1:1]};   // LSB first.
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == BW - 1) begin
                                stop_cnt <= '0;
                                state    <= RX_STOP;
                            end
                        end
                    end
                end
                RX_STOP: begin
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == 4'd15) begin
                            stop_cnt <= stop_cnt + 1'b1;
                            if (!i_rx) begin
                                state <= RX_IDLE;              // Framing error, byte dropped.
                            end else begin
                                // Byte is handed over at the middle of the first stop bit.
                                o_rx_done <= (stop_cnt == 2'd0);
                                if (stop_cnt == 2'(STOP_BITS - 1)) begin
                                    state <= RX_IDLE;
                                end
                            end
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int STOP_BITS = 1
) (
    input  logic                              i_clock,
    input  logic                              i_rst_n,
    input  logic                              i_tick,
    input  logic                              i_tx_start,
    input  logic [loader_pkg::BYTE_WIDTH-1:0] i_data,
    output logic                              o_tx,
    output logic                              o_tx_done
);
    localparam int BW = loader_pkg::BYTE_WIDTH;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    tx_state_e              state;
    logic [3:0]             tick_cnt;
    logic [$clog2(BW)-1:0]  bit_cnt;
    logic [1:0]             stop_cnt;
    logic [BW-1:0]          shreg;      // Byte being sent.

    always_comb begin
        case (state)
            TX_START: o_tx = 1'b0;
            TX_DATA:  o_tx = shreg[0];
            default:  o_tx = 1'b1;      // Idle and stop bits.
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state     <= TX_IDLE;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            stop_cnt  <= '0;
            o_tx_done <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            case (state)
                TX_IDLE: begin
                    if (i_tx_start) begin
                        shreg    <= i_data;
                        tick_cnt <= '0;
                        state    <= TX_START;
                    end
                end
                TX_START: begin
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == 4'd15) begin
                            bit_cnt <= '0;
                            state   <= TX_DATA;
                        end
                    end
                end
                TX_DATA: begin
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == 4'd15) begin
                            shreg   <= shreg >> 1;
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == BW - 1) begin
                                stop_cnt <= '0;
                                state    <= TX_STOP;
                            end
                        end
                    end
                end
                TX_STOP: begin
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                        if (tick_cnt == 4'd15) begin
                            stop_cnt <= stop_cnt + 1'b1;
                            if (stop_cnt == 2'(STOP_BITS - 1)) begin
                                o_tx_done <= 1'b1;       // End of last stop bit.
                                state     <= TX_IDLE;
                            end
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/debug_unit.sv
`timescale 1ns/1ps

module debug_unit #(
    parameter int PROG_ADDR_WIDTH = 11,
    parameter int DATA_ADDR_WIDTH = 10,
    parameter int HALT_OPCODE     = 0
) (
    input  logic                              i_clock,
    input  logic                              i_rst_n,
    input  logic                              i_rx_done,
    input  logic [loader_pkg::BYTE_WIDTH-1:0] i_rx_data,
    input  logic                              i_tx_done,
    output logic                              o_tx_start,
    output logic [loader_pkg::BYTE_WIDTH-1:0] o_tx_data,
    output logic                              o_led_halt,
    mem_port_if.master                        prog,
    mem_port_if.master                        data
);
    localparam int WW = loader_pkg::WORD_WIDTH;
    localparam int BW = loader_pkg::BYTE_WIDTH;

    loader_pkg::dbg_state_e state;
    loader_pkg::cmd_e       opcode;
    logic [2*BW-1:0]        addr_reg;     // Two address bytes, low first.
    logic [WW-1:0]          word_reg;     // Write data.
    logic [WW-1:0]          reply_buf;
    logic [1:0]             byte_cnt;
    logic [1:0]             reply_last;   // Reply length minus one.
    logic                   mem_wait;     // Read issued, rdata due.
    logic                   tx_busy;
    logic                   is_write;
    logic                   is_prog;
    logic                   access;

    assign is_write = (opcode == loader_pkg::CMD_WR_PROG) || (opcode == loader_pkg::CMD_WR_DATA);
    assign is_prog  = (opcode == loader_pkg::CMD_WR_PROG) || (opcode == loader_pkg::CMD_RD_PROG);
    assign access   = (state == loader_pkg::MEM_ACCESS) && !mem_wait;

    ////////////////////////////////////////
    // Memory ports.
    ////////////////////////////////////////
    assign prog.en         = access && is_prog;
    assign prog.we         = access && is_write;
    assign prog.addr       = addr_reg[PROG_ADDR_WIDTH-1:0];
    assign prog.wdata      = word_reg;
    assign prog.soft_reset = (state == loader_pkg::CLEAR_WAIT);

    assign data.en         = access && !is_prog;
    assign data.we         = access && is_write;
    assign data.addr       = addr_reg[DATA_ADDR_WIDTH-1:0];
    assign data.wdata      = word_reg;
    assign data.soft_reset = (state == loader_pkg::CLEAR_WAIT);

    assign o_tx_data = reply_buf[BW-1:0];   // Reply goes out LSB first.

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state      <= loader_pkg::IDLE;
            byte_cnt   <= '0;
            reply_last <= '0;
            mem_wait   <= 1'b0;
            tx_busy    <= 1'b0;
            o_tx_start <= 1'b0;
            o_led_halt <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;
            case (state)
                loader_pkg::IDLE: begin
                    if (i_rx_done) begin
                        opcode   <= loader_pkg::cmd_e'(i_rx_data);
                        byte_cnt <= '0;
                        case (loader_pkg::cmd_e'(i_rx_data))
                            loader_pkg::CMD_WR_PROG, loader_pkg::CMD_WR_DATA,
                            loader_pkg::CMD_RD_PROG, loader_pkg::CMD_RD_DATA: begin
                                state <= loader_pkg::ADDR;
                            end
                            loader_pkg::CMD_CLEAR: begin
                                o_led_halt <= 1'b0;
                                state      <= loader_pkg::CLEAR_WAIT;
                            end
                            default: begin
                                reply_buf  <= WW'(loader_pkg::REPLY_ERR);
                                reply_last <= 2'd0;
                                state      <= loader_pkg::SEND;
                            end
                        endcase
                    end
                end
                loader_pkg::ADDR: begin
                    if (i_rx_done) begin
                        addr_reg <= {i_rx_data, addr_reg[2*BW-1:BW]};
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd1) begin
                            byte_cnt <= '0;
                            state    <= is_write ? loader_pkg::DATA : loader_pkg::MEM_ACCESS;
                        end
                    end
                end
                loader_pkg::DATA: begin
                    if (i_rx_done) begin
                        word_reg <= {i_rx_data, word_reg[WW-1:BW]};
                        byte_cnt <= byte_cnt + 1'b1;   // Wraps back to zero.
                        if (byte_cnt == 2'd3) begin
                            state <= loader_pkg::MEM_ACCESS;
                        end
                    end
                end
                loader_pkg::MEM_ACCESS: begin
                    if (!mem_wait && is_write) begin
                        if (is_prog && word_reg[loader_pkg::OPCODE_LSB +: 6] == 6'(HALT_OPCODE)) begin
                            o_led_halt <= 1'b1;                  // HALT loaded.
                        end
                        reply_buf  <= WW'(loader_pkg::REPLY_OK);
                        reply_last <= 2'd0;
                        state      <= loader_pkg::SEND;
                    end else if (!mem_wait) begin
                        mem_wait <= 1'b1;
                    end else begin
                        mem_wait   <= 1'b0;
                        reply_buf  <= is_prog ? prog.rdata : data.rdata;
                        reply_last <= 2'd3;
                        state      <= loader_pkg::SEND;
                    end
                end
                loader_pkg::CLEAR_WAIT: begin
                    // Data memory answers early; wait for the program sweep too.
                    if (prog.reset_ack && data.reset_ack) begin
                        reply_buf  <= WW'(loader_pkg::REPLY_OK);
                        reply_last <= 2'd0;
                        state      <= loader_pkg::SEND;
                    end
                end
                loader_pkg::SEND: begin
                    if (!tx_busy) begin
                        o_tx_start <= 1'b1;
                        tx_busy    <= 1'b1;
                    end else if (i_tx_done) begin
                        tx_busy   <= 1'b0;
                        reply_buf <= reply_buf >> BW;        // Next byte.
                        byte_cnt  <= byte_cnt + 1'b1;
                        if (byte_cnt == reply_last) begin
                            byte_cnt <= '0;
                            state    <= loader_pkg::IDLE;
                        end
                    end
                end
                default: state <= loader_pkg::IDLE;
            endcase
        end
    end

endmodule

//--- rtl/program_memory.sv
`timescale 1ns/1ps

module program_memory #(
    parameter int ADDR_WIDTH = 11
) (
    input  logic       i_clock,
    input  logic       i_rst_n,
    mem_port_if.slave  port
);
    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [loader_pkg::WORD_WIDTH-1:0] mem [DEPTH];
    logic [ADDR_WIDTH-1:0]             clr_cnt;
    logic                              clr_done;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Clear sweep writes one word per cycle.
    always_ff @(posedge i_clock) begin
        if (port.soft_reset && !clr_done) begin
            mem[clr_cnt] <= '0;
        end else if (port.en && port.we) begin
            mem[port.addr] <= port.wdata;
        end
        if (port.en) begin
            port.rdata <= mem[port.addr];
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n || !port.soft_reset) begin
            clr_cnt        <= '0;
            clr_done       <= 1'b0;
            port.reset_ack <= 1'b0;     // Falls one cycle after soft_reset.
        end else begin
            port.reset_ack <= clr_done;
            if (!clr_done) begin
                clr_cnt  <= clr_cnt + 1'b1;
                clr_done <= (clr_cnt == '1);
            end
        end
    end

endmodule

//--- rtl/data_memory.sv
`timescale 1ns/1ps

module data_memory #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic       i_clock,
    input  logic       i_rst_n,
    mem_port_if.slave  port
);
    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [loader_pkg::WORD_WIDTH-1:0] mem [DEPTH];
    logic [DEPTH-1:0]                  dirty;   // Set once a word is written.

    ////////////////////////////////////////
    // Storage and registered read.
    ////////////////////////////////////////
    always_ff @(posedge i_clock) begin
        if (port.en && port.we) begin
            mem[port.addr] <= port.wdata;
        end
        if (port.en) begin
            // Words untouched since the last clear read as zero.
            port.rdata <= dirty[port.addr] ? mem[port.addr] : '0;
        end
    end

    ////////////////////////////////////////
    // Dirty bits and clear handshake.
    ////////////////////////////////////////
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            dirty          <= '0;
            port.reset_ack <= 1'b0;
        end else begin
            // Whole array clears in one cycle, so ack just follows soft_reset.
            port.reset_ack <= port.soft_reset;
            if (port.soft_reset) begin
                dirty <= '0;
            end else if (port.en && port.we) begin
                dirty[port.addr] <= 1'b1;
            end
        end
    end

endmodule

//--- rtl/top_arquitectura.sv
`timescale 1ns/1ps

module top_arquitectura #(
    parameter int CLKS_PER_TICK = 651,   // 100 MHz at 9600 baud, 16x.
    parameter int STOP_BITS     = 2,
    parameter int HALT_OPCODE   = 0
) (
    input  logic i_clock,
    input  logic i_rst_n,
    input  logic i_uart_rx,    // From host.
    output logic o_uart_tx,    // To host.
    output logic o_led_halt
);
    localparam int PROG_ADDR_WIDTH = 11;
    localparam int DATA_ADDR_WIDTH = 10;

    logic                              tick;
    logic                              rx_done;
    logic                              tx_done;
    logic                              tx_start;
    logic [loader_pkg::BYTE_WIDTH-1:0] rx_data;
    logic [loader_pkg::BYTE_WIDTH-1:0] tx_data;

    mem_port_if #(.ADDR_WIDTH(PROG_ADDR_WIDTH)) prog_bus ();
    mem_port_if #(.ADDR_WIDTH(DATA_ADDR_WIDTH)) data_bus ();

    ////////////////////////////////////////
    // Serial link.
    ////////////////////////////////////////
    baud_rate_generator #(.CLKS_PER_TICK(CLKS_PER_TICK)) u_baud_rate_generator (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .o_tick  (tick)
    );

    uart_rx #(.STOP_BITS(STOP_BITS)) u_uart_rx (
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .i_tick    (tick),
        .i_rx      (i_uart_rx),
        .o_rx_done (rx_done),
        .o_data    (rx_data)
    );

    uart_tx #(.STOP_BITS(STOP_BITS)) u_uart_tx (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_tick     (tick),
        .i_tx_start (tx_start),
        .i_data     (tx_data),
        .o_tx       (o_uart_tx),
        .o_tx_done  (tx_done)
    );

    ////////////////////////////////////////
    // Command decoder and memories.
    ////////////////////////////////////////
    debug_unit #(
        .PROG_ADDR_WIDTH (PROG_ADDR_WIDTH),
        .DATA_ADDR_WIDTH (DATA_ADDR_WIDTH),
        .HALT_OPCODE     (HALT_OPCODE)
    ) u_debug_unit (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_rx_done  (rx_done),
        .i_rx_data  (rx_data),
        .i_tx_done  (tx_done),
        .o_tx_start (tx_start),
        .o_tx_data  (tx_data),
        .o_led_halt (o_led_halt),
        .prog       (prog_bus.master),
        .data       (data_bus.master)
    );

    program_memory #(.ADDR_WIDTH(PROG_ADDR_WIDTH)) u_program_memory (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .port    (prog_bus.slave)
    );

    data_memory #(.ADDR_WIDTH(DATA_ADDR_WIDTH)) u_data_memory (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .port    (data_bus.slave)
    );

endmodule

//--- tb/top_assertions.sv
`timescale 1ns/1ps

module top_assertions (
    input logic                   i_clock,
    input logic                   i_rst_n,
    input logic                   i_tx_start,
    input logic                   i_tx_done,
    input logic                   i_tx,
    input loader_pkg::dbg_state_e i_state,
    input logic                   i_prog_en,
    input logic                   i_prog_soft_reset,
    input logic                   i_prog_reset_ack,
    input logic                   i_data_en,
    input logic                   i_data_soft_reset,
    input logic                   i_data_reset_ack
);
    int   fail_count = 0;   // Read by the testbench at the end.
    logic tx_active;        // Transmitter holds the line.
    logic in_reset_q;

    always_ff @(posedge i_clock) begin
        in_reset_q <= !i_rst_n;
        if (!i_rst_n) begin
            tx_active <= 1'b0;
        end else if (i_tx_start) begin
            tx_active <= 1'b1;
        end else if (i_tx_done) begin
            tx_active <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Debug unit and memory ports.
    ////////////////////////////////////////
    start_when_idle: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_tx_start |-> !tx_active)
        else begin
            $error("tx_start issued while the transmitter is busy");
            fail_count++;
        end

    // CLEAR_WAIT is left only with both acknowledges high.
    clear_needs_acks: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        (i_state == loader_pkg::CLEAR_WAIT) && !(i_prog_reset_ack && i_data_reset_ack)
        |=> (i_state == loader_pkg::CLEAR_WAIT))
        else begin
            $error("clear finished before both memories acknowledged");
            fail_count++;
        end

    // No access until the memory has dropped its acknowledge again.
    prog_no_access_in_clear: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        !(i_prog_en && (i_prog_soft_reset || i_prog_reset_ack)))
        else begin
            $error("program port access while a clear is pending");
            fail_count++;
        end

    data_no_access_in_clear: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        !(i_data_en && (i_data_soft_reset || i_data_reset_ack)))
        else begin
            $error("data port access while a clear is pending");
            fail_count++;
        end

    line_idle_in_reset: assert property (@(posedge i_clock)
        in_reset_q && !i_rst_n |-> i_tx)
        else begin
            $error("serial output low during reset");
            fail_count++;
        end

endmodule

bind top_arquitectura top_assertions u_assertions (
    .i_clock           (i_clock),
    .i_rst_n           (i_rst_n),
    .i_tx_start        (tx_start),
    .i_tx_done         (tx_done),
    .i_tx              (o_uart_tx),
    .i_state           (u_debug_unit.state),
    .i_prog_en         (prog_bus.en),
    .i_prog_soft_reset (prog_bus.soft_reset),
    .i_prog_reset_ack  (prog_bus.reset_ack),
    .i_data_en         (data_bus.en),
    .i_data_soft_reset (data_bus.soft_reset),
    .i_data_reset_ack  (data_bus.reset_ack)
);

//--- tb/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int CLKS_PER_TICK = 4;
    localparam int STOP_BITS     = 2;
    localparam int HALT_OPCODE   = 0;
    localparam int BIT_CLKS      = 16 * CLKS_PER_TICK;   // One serial bit.
    localparam int REPLY_TIMEOUT = 20000;                // Longest frame plus clear sweep.

    logic i_clock;
    logic i_rst_n;
    logic i_uart_rx;
    logic o_uart_tx;
    logic o_led_halt;

    logic [7:0] frame_q [$];   // Host to DUT.
    logic [7:0] reply_q [$];   // DUT to host.
    int         errors;
    int         timeouts;
    int         assert_fails;

    top_arquitectura #(
        .CLKS_PER_TICK (CLKS_PER_TICK),
        .STOP_BITS     (STOP_BITS),
        .HALT_OPCODE   (HALT_OPCODE)
    ) u_dut (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_uart_rx  (i_uart_rx),
        .o_uart_tx  (o_uart_tx),
        .o_led_halt (o_led_halt)
    );

    initial begin
        i_clock = 1'b0;
        forever #10 i_clock = ~i_clock;
    end

    ////////////////////////////////////////
    // Serial host model.
    ////////////////////////////////////////
    task automatic drive_bit(input logic value);
        i_uart_rx = value;
        repeat (BIT_CLKS) @(posedge i_clock);
        #2;
    endtask

    task automatic send_frame();
        foreach (frame_q[k]) begin
            drive_bit(1'b0);                       // Start bit.
            for (int i = 0; i < 8; i++) begin
                drive_bit(frame_q[k][i]);          // LSB first.
            end
            repeat (STOP_BITS) drive_bit(1'b1);
        end
    endtask

    task automatic collect_reply(input string name, input int count);
        int         wait_cnt;
        logic [7:0] rx_byte;
        reply_q.delete();
        for (int k = 0; k < count; k++) begin
            wait_cnt = 0;
            while (o_uart_tx !== 1'b0 && wait_cnt < REPLY_TIMEOUT) begin
                @(negedge i_clock);
                wait_cnt++;
            end
            if (o_uart_tx !== 1'b0) begin
                $display("%s: no start bit for reply byte %0d within %0d cycles",
                         name, k, REPLY_TIMEOUT);
                timeouts++;
                return;
            end
            repeat (BIT_CLKS / 2) @(negedge i_clock);   // Middle of start bit.
            if (o_uart_tx !== 1'b0) begin
                $display("%s: start bit of reply byte %0d did not stay low", name, k);
                errors++;
            end
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(negedge i_clock);
                rx_byte[i] = o_uart_tx;
            end
            for (int s = 0; s < STOP_BITS; s++) begin
                repeat (BIT_CLKS) @(negedge i_clock);
                if (o_uart_tx !== 1'b1) begin
                    $display("%s: stop bit %0d of reply byte %0d is low", name, s, k);
                    errors++;
                end
            end
            reply_q.push_back(rx_byte);
        end
    endtask

    // Reply can start before the frame's last stop bit ends.
    task automatic run_command(input string name, input int reply_len);
        fork
            send_frame();
            collect_reply(name, reply_len);
        join
        @(posedge i_clock);
        #2;
    endtask

    ////////////////////////////////////////
    // Checks and commands.
    ////////////////////////////////////////
    task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected %02h, actual %02h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_led(input string name, input logic exp);
        if (o_led_halt !== exp) begin
            $display("FAILED %s: expected %0b, actual %0b", name, exp, o_led_halt);
            errors++;
        end
    endtask

    task automatic write_word(input string name, input loader_pkg::cmd_e cmd,
                              input logic [15:0] addr, input logic [31:0] word);
        frame_q.delete();
        frame_q.push_back(8'(cmd));
        frame_q.push_back(addr[7:0]);
        frame_q.push_back(addr[15:8]);
        for (int i = 0; i < 4; i++) begin
            frame_q.push_back(word[8*i +: 8]);
        end
        run_command(name, 1);
        if (reply_q.size() == 1) begin
            compare_byte(name, 8'hAA, reply_q[0]);
        end
    endtask

    task automatic read_word(input string name, input loader_pkg::cmd_e cmd,
                             input logic [15:0] addr, input logic [31:0] exp);
        frame_q.delete();
        frame_q.push_back(8'(cmd));
        frame_q.push_back(addr[7:0]);
        frame_q.push_back(addr[15:8]);
        run_command(name, 4);
        for (int i = 0; i < reply_q.size(); i++) begin
            compare_byte($sformatf("%s byte %0d", name, i), exp[8*i +: 8], reply_q[i]);
        end
    endtask

    task automatic lone_opcode(input string name, input logic [7:0] opcode,
                               input logic [7:0] exp_reply);
        frame_q.delete();
        frame_q.push_back(opcode);
        run_command(name, 1);
        if (reply_q.size() == 1) begin
            compare_byte(name, exp_reply, reply_q[0]);
        end
    endtask

    // Random word, opcode field forced to halt or kept off it.
    function automatic logic [31:0] make_word(input bit halt);
        logic [5:0] op;
        op = 6'($urandom);
        if (halt) begin
            op = 6'(HALT_OPCODE);
        end else if (op == 6'(HALT_OPCODE)) begin
            op = op + 6'd1;
        end
        return {op, 26'($urandom)};
    endfunction

    initial begin
        logic [15:0] addr;
        logic [31:0] word;
        logic [31:0] data_word;

        void'($urandom(32'hf326815d));
        errors    = 0;
        timeouts  = 0;
        i_rst_n   = 1'b0;
        i_uart_rx = 1'b1;                     // Line idle.
        repeat (10) @(posedge i_clock);
        #2;
        i_rst_n = 1'b1;
        repeat (4) @(posedge i_clock);
        #2;

        // Program memory round trip.
        for (int n = 0; n < 4; n++) begin
            addr = 16'($urandom) & 16'h07FF;
            word = make_word(1'b0);
            write_word($sformatf("prog write %0d", n), loader_pkg::CMD_WR_PROG, addr, word);
            read_word($sformatf("prog read %0d", n), loader_pkg::CMD_RD_PROG, addr, word);
        end
        check_led("halt led after plain words", 1'b0);

        // Data memory and the dirty rule.
        data_word = make_word(1'b0);
        write_word("data write", loader_pkg::CMD_WR_DATA, 16'h0155, data_word);
        read_word("data read", loader_pkg::CMD_RD_DATA, 16'h0155, data_word);
        read_word("data read unwritten", loader_pkg::CMD_RD_DATA, 16'h02AA, 32'h0);

        // Halt word, then clear.
        write_word("halt write", loader_pkg::CMD_WR_PROG, 16'h0040, make_word(1'b1));
        check_led("halt led set", 1'b1);
        lone_opcode("clear", 8'(loader_pkg::CMD_CLEAR), 8'hAA);
        check_led("halt led after clear", 1'b0);
        read_word("data read after clear", loader_pkg::CMD_RD_DATA, 16'h0155, 32'h0);
        read_word("prog read after clear", loader_pkg::CMD_RD_PROG, 16'h0040, 32'h0);

        // Unknown opcode, then a normal frame.
        lone_opcode("unknown opcode", 8'h7F, 8'hEE);
        data_word = make_word(1'b0);
        write_word("data write after error", loader_pkg::CMD_WR_DATA, 16'h0033, data_word);
        read_word("data read after error", loader_pkg::CMD_RD_DATA, 16'h0033, data_word);

        assert_fails = u_dut.u_assertions.fail_count;
        $display("Done: %0d errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, assert_fails);
        if (errors + timeouts + assert_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
rtl/loader_pkg.sv
rtl/mem_port_if.sv
rtl/baud_rate_generator.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/debug_unit.sv
rtl/program_memory.sv
rtl/data_memory.sv
rtl/top_arquitectura.sv
tb/top_assertions.sv
tb/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG SIM_ARGS"

test:
	$(VERILATOR) --binary --timing --assert -Wno-fatal -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
